/* Makefile */
# Verilator build and run of the scoreboard testbench

TOP := tb_scoreboard

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

# A $$fatal in the run gives a nonzero exit status, so make fails too
test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f flist.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+.
scoreboard_pkg.sv
pipe_unit_tracker.sv
seq_unit_tracker.sv
issue_arbiter.sv
scoreboard_top.sv
scoreboard_assert.sv
tb_scoreboard.sv

/* issue_arbiter.sv */
`timescale 1ns/1ps

`include "scoreboard_defs.svh"

module issue_arbiter
    import scoreboard_pkg::*;
(
    input  logic  instr_valid_i,
    input  unit_t instr_unit_i,
    input  logic  mul_raw_hazard_i,
    input  logic  mul_latency_hazard_i,
    input  logic  mul_busy_i,
    input  logic  div_raw_hazard_i,
    input  logic  div_latency_hazard_i,
    input  logic  div_busy_i,
    output logic  instr_ready_o,
    output logic  mul_issue_o,
    output logic  div_issue_o,
    output logic  pipeline_empty_o
);

    logic raw_hazard;
    logic latency_hazard;
    logic structural_hazard;
    logic issue;

    //==================================================
    // Hazard merge
    //==================================================

    assign raw_hazard     = mul_raw_hazard_i | div_raw_hazard_i;
    assign latency_hazard = mul_latency_hazard_i | div_latency_hazard_i;

    // Divider is not pipelined, a second DIV must wait
    assign structural_hazard = (instr_unit_i == DIV) && div_busy_i;

    // Ready does not depend on valid
    assign instr_ready_o = !(raw_hazard | latency_hazard | structural_hazard);

    //==================================================
    // Issue strobes
    //==================================================

    // Handshake completes at this edge
    assign issue = instr_valid_i && instr_ready_o;

    // ALU ops are not tracked, so no strobe for them
    assign mul_issue_o = issue && (instr_unit_i == MUL);
    assign div_issue_o = issue && (instr_unit_i == DIV);

    // Nothing in flight in either unit
    assign pipeline_empty_o = !(mul_busy_i | div_busy_i);

endmodule : issue_arbiter

/* pipe_unit_tracker.sv */
`timescale 1ns/1ps

`include "scoreboard_defs.svh"

module pipe_unit_tracker
    import scoreboard_pkg::*;
#(
    // Number of slots, one per pipeline stage of the unit
    parameter int unsigned LATENCY = `MUL_LATENCY
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      issue_i,
    input  unit_t     unit_i,
    input  reg_addr_t src0_i,
    input  reg_addr_t src1_i,
    input  reg_addr_t dest_i,
    output logic      raw_hazard_o,
    output logic      latency_hazard_o,
    output logic      busy_o
);

    // Value a slot takes when loaded
    localparam latency_cnt_t LOAD_CNT = latency_cnt_t'(LATENCY + `BYPASS_STAGES);

    //==================================================
    // Slot pointer
    //==================================================

    // One-hot, marks the slot the next issue fills
    logic [LATENCY-1:0] slot_ptr;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_ptr <= LATENCY'(1);
        end else if (flush_i) begin
            // Back to slot 0
            slot_ptr <= LATENCY'(1);
        end else if (issue_i) begin
            if (slot_ptr[LATENCY-1]) begin
                // Wrap from the last slot
                slot_ptr <= LATENCY'(1);
            end else begin
                slot_ptr <= slot_ptr << 1;
            end
        end
    end

    //==================================================
    // Slot state and compares
    //==================================================

    latency_cnt_t       slot_cnt  [LATENCY];
    reg_addr_t          slot_dest [LATENCY];
    logic [LATENCY-1:0] slot_busy;
    logic [LATENCY-1:0] slot_raw;
    logic [LATENCY-1:0] slot_lat;

    // Writeback distance of the instruction now offered
    latency_cnt_t in_latency;

    assign in_latency = writeback_latency(unit_i);

    for (genvar i = 0; i < LATENCY; i++) begin : g_slot
        // Latency counter
        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                slot_cnt[i] <= '0;
            end else if (flush_i) begin
                slot_cnt[i] <= '0;
            end else if (issue_i && slot_ptr[i]) begin
                slot_cnt[i] <= LOAD_CNT;
            end else if (slot_cnt[i] != '0) begin
                // Count down, keeps running while issue waits
                slot_cnt[i] <= slot_cnt[i] - 1'b1;
            end
        end

        // Destination of the op held in this slot
        always_ff @(posedge clk_i) begin
            if (issue_i && slot_ptr[i]) begin
                slot_dest[i] <= dest_i;
            end
        end

        // Result still in flight
        assign slot_busy[i] = (slot_cnt[i] > latency_cnt_t'(1));

        // Any operand of the new op matches a pending write, x0 exempt
        assign slot_raw[i] = slot_busy[i]
                           && (slot_dest[i] != '0)
                           && ((slot_dest[i] == src0_i)
                            || (slot_dest[i] == src1_i)
                            || (slot_dest[i] == dest_i));

        // Both results would reach writeback in the same cycle
        assign slot_lat[i] = slot_busy[i] && (slot_cnt[i] == in_latency);
    end

    //==================================================
    // Reduction
    //==================================================

    assign raw_hazard_o     = |slot_raw;
    assign latency_hazard_o = |slot_lat;
    assign busy_o           = |slot_busy;

endmodule : pipe_unit_tracker

/* scoreboard_assert.sv */
`timescale 1ns/1ps

module scoreboard_assert (
    input logic clk_i,
    input logic rst_n_i,
    input logic flush_i,
    input logic ready_i,
    input logic empty_i,
    input logic div_issue_i
);

    //==================================================
    // Handshake and tracking properties
    //==================================================

    // Nothing in flight leaves no hazard to stall on
    property empty_gives_ready;
        @(posedge clk_i) disable iff (!rst_n_i)
        empty_i |-> ready_i;
    endproperty

    // Flush discards every tracked result
    property flush_empties;
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> empty_i;
    endproperty

    // A DIV stays busy well past the next edge, unless flushed at issue
    property div_fills;
        @(posedge clk_i) disable iff (!rst_n_i)
        (div_issue_i && !flush_i) |=> !empty_i;
    endproperty

    a_empty_ready: assert property (empty_gives_ready)
        else $error("pipeline empty while ready is low");
    a_flush_empty: assert property (flush_empties)
        else $error("pipeline not empty one cycle after flush");
    a_div_busy: assert property (div_fills)
        else $error("pipeline empty one cycle after a DIV issue");

endmodule : scoreboard_assert

bind scoreboard_top scoreboard_assert u_scoreboard_assert (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .ready_i     (instr_ready_o),
    .empty_i     (pipeline_empty_o),
    .div_issue_i (div_issue)
);

/* scoreboard_defs.svh */
`ifndef SCOREBOARD_DEFS_SVH
`define SCOREBOARD_DEFS_SVH

//==================================================
// Register file geometry
//==================================================

// Architectural register address width
`define REG_ADDR_W 5

//==================================================
// Execution timing
//==================================================

// Stages between issue and the start of execution
`define BYPASS_STAGES 1

// Execution cycles of each integer unit
`define ALU_LATENCY 1
`define MUL_LATENCY 5
`define DIV_LATENCY 36

// Counter width, must hold DIV_LATENCY plus the bypass stages
`define CNT_W 6

`endif

/* scoreboard_pkg.sv */
`include "scoreboard_defs.svh"

package scoreboard_pkg;

    // Architectural register address
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Cycles left until writeback
    typedef logic [`CNT_W-1:0] latency_cnt_t;

    // Integer unit select, CSR ops go to the ALU
    typedef enum logic [1:0] {
        ALU = 2'd0,
        MUL = 2'd1,
        DIV = 2'd2
    } unit_t;

    // Writeback distance seen from the issue edge
    localparam latency_cnt_t W_ALU = latency_cnt_t'(`ALU_LATENCY + `BYPASS_STAGES);
    localparam latency_cnt_t W_MUL = latency_cnt_t'(`MUL_LATENCY + `BYPASS_STAGES);
    localparam latency_cnt_t W_DIV = latency_cnt_t'(`DIV_LATENCY + `BYPASS_STAGES);

    // Unit to writeback latency
    function automatic latency_cnt_t writeback_latency(input unit_t unit);
        case (unit)
            MUL:     return W_MUL;
            DIV:     return W_DIV;
            // Unused encoding treated as ALU
            default: return W_ALU;
        endcase
    endfunction

endpackage : scoreboard_pkg

/* scoreboard_top.sv */
`timescale 1ns/1ps

`include "scoreboard_defs.svh"

module scoreboard_top
    import scoreboard_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      instr_valid_i,
    input  unit_t     instr_unit_i,
    input  reg_addr_t src0_i,
    input  reg_addr_t src1_i,
    input  reg_addr_t dest_i,
    output logic      instr_ready_o,
    output logic      pipeline_empty_o
);

    // Tracker status toward the arbiter
    logic mul_raw_hazard;
    logic mul_latency_hazard;
    logic mul_busy;
    logic div_raw_hazard;
    logic div_latency_hazard;
    logic div_busy;

    // Per-unit issue strobes
    logic mul_issue;
    logic div_issue;

    //==================================================
    // Unit trackers
    //==================================================

    // Pipelined multiplier, one slot per stage
    pipe_unit_tracker #(
        .LATENCY (`MUL_LATENCY)
    ) u_mul_tracker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .issue_i          (mul_issue),
        .unit_i           (instr_unit_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .raw_hazard_o     (mul_raw_hazard),
        .latency_hazard_o (mul_latency_hazard),
        .busy_o           (mul_busy)
    );

    // Sequential divider
    seq_unit_tracker #(
        .LATENCY (`DIV_LATENCY)
    ) u_div_tracker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .issue_i          (div_issue),
        .unit_i           (instr_unit_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .raw_hazard_o     (div_raw_hazard),
        .latency_hazard_o (div_latency_hazard),
        .busy_o           (div_busy)
    );

    //==================================================
    // Issue decision
    //==================================================

    issue_arbiter u_issue_arbiter (
        .instr_valid_i        (instr_valid_i),
        .instr_unit_i         (instr_unit_i),
        .mul_raw_hazard_i     (mul_raw_hazard),
        .mul_latency_hazard_i (mul_latency_hazard),
        .mul_busy_i           (mul_busy),
        .div_raw_hazard_i     (div_raw_hazard),
        .div_latency_hazard_i (div_latency_hazard),
        .div_busy_i           (div_busy),
        .instr_ready_o        (instr_ready_o),
        .mul_issue_o          (mul_issue),
        .div_issue_o          (div_issue),
        .pipeline_empty_o     (pipeline_empty_o)
    );

endmodule : scoreboard_top

/* seq_unit_tracker.sv */
`timescale 1ns/1ps

`include "scoreboard_defs.svh"

module seq_unit_tracker
    import scoreboard_pkg::*;
#(
    // Execution cycles of the sequential unit
    parameter int unsigned LATENCY = `DIV_LATENCY
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      issue_i,
    input  unit_t     unit_i,
    input  reg_addr_t src0_i,
    input  reg_addr_t src1_i,
    input  reg_addr_t dest_i,
    output logic      raw_hazard_o,
    output logic      latency_hazard_o,
    output logic      busy_o
);

    // Counter value right after the issue edge
    localparam latency_cnt_t LOAD_CNT = latency_cnt_t'(LATENCY + `BYPASS_STAGES);

    latency_cnt_t op_cnt;
    reg_addr_t    op_dest;
    latency_cnt_t in_latency;

    // Only one op at a time, so a single counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_cnt <= '0;
        end else if (flush_i) begin
            op_cnt <= '0;
        end else if (issue_i) begin
            op_cnt <= LOAD_CNT;
        end else if (op_cnt != '0) begin
            op_cnt <= op_cnt - 1'b1;
        end
    end

    // Destination of the op in the unit
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            op_dest <= dest_i;
        end
    end

    assign in_latency = writeback_latency(unit_i);

    // Busy flag also drives the structural check in the arbiter
    assign busy_o = (op_cnt > latency_cnt_t'(1));

    // Pending write to a register the new op touches
    assign raw_hazard_o = busy_o
                        && (op_dest != '0)
                        && ((op_dest == src0_i)
                         || (op_dest == src1_i)
                         || (op_dest == dest_i));

    // Same writeback cycle as the offered op
    assign latency_hazard_o = busy_o && (op_cnt == in_latency);

endmodule : seq_unit_tracker

/* tb_scoreboard.sv */
`timescale 1ns/1ps

`include "scoreboard_defs.svh"

module tb_scoreboard
    import scoreboard_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int RANDOM_CYCLES   = 2000;
    // Directed part takes about 250 cycles
    localparam int DIRECTED_CYCLES = 400;
    localparam int MARGIN_CYCLES   = 500;
    localparam int NUM_SLOTS       = `MUL_LATENCY;

    logic      clk_i;
    logic      rst_n_i;
    logic      flush_i;
    logic      instr_valid_i;
    unit_t     instr_unit_i;
    reg_addr_t src0_i;
    reg_addr_t src1_i;
    reg_addr_t dest_i;
    logic      instr_ready_o;
    logic      pipeline_empty_o;

    // Reference model of the tracked results
    int        mul_cnt [NUM_SLOTS];
    reg_addr_t mul_dst [NUM_SLOTS];
    int        mul_ptr;
    int        div_cnt;
    reg_addr_t div_dst;

    int        error_count;
    int        waited;
    int        refusals;
    // Offered op was refused at the last edge, source must hold it
    logic      stalled;

    scoreboard_top dut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .instr_valid_i    (instr_valid_i),
        .instr_unit_i     (instr_unit_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .instr_ready_o    (instr_ready_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //==================================================
    // Reference model
    //==================================================

    // Writeback distance counted from the issue edge
    function automatic int unit_latency(input unit_t unit);
        case (unit)
            MUL:     return `MUL_LATENCY + `BYPASS_STAGES;
            DIV:     return `DIV_LATENCY + `BYPASS_STAGES;
            default: return `ALU_LATENCY + `BYPASS_STAGES;
        endcase
    endfunction

    // Pending write that the offered op reads or overwrites, x0 never counts
    function automatic logic reg_conflict(input reg_addr_t pend);
        return (pend != '0) && ((pend == src0_i) || (pend == src1_i) || (pend == dest_i));
    endfunction

    function automatic logic expected_ready();
        int   w;
        logic hazard;
        w = unit_latency(instr_unit_i);
        hazard = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if ((mul_cnt[i] > 1) && (reg_conflict(mul_dst[i]) || (mul_cnt[i] == w))) begin
                hazard = 1'b1;
            end
        end
        // Divider also blocks any second DIV while busy
        if ((div_cnt > 1) && (reg_conflict(div_dst) || (div_cnt == w)
                              || (instr_unit_i == DIV))) begin
            hazard = 1'b1;
        end
        return !hazard;
    endfunction

    function automatic logic expected_empty();
        logic idle;
        idle = (div_cnt <= 1);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (mul_cnt[i] > 1) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    // One clock edge of the counter rule, flush wins over issue
    task automatic update_model();
        logic issue;
        issue = instr_valid_i && expected_ready();
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                mul_cnt[i] = 0;
            end
            mul_ptr = 0;
            div_cnt = 0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (issue && (instr_unit_i == MUL) && (mul_ptr == i)) begin
                    mul_cnt[i] = unit_latency(MUL);
                    mul_dst[i] = dest_i;
                end else if (mul_cnt[i] > 0) begin
                    mul_cnt[i]--;
                end
            end
            if (issue && (instr_unit_i == MUL)) begin
                mul_ptr = (mul_ptr + 1) % NUM_SLOTS;
            end
            if (issue && (instr_unit_i == DIV)) begin
                div_cnt = unit_latency(DIV);
                div_dst = dest_i;
            end else if (div_cnt > 0) begin
                div_cnt--;
            end
        end
    endtask

    //==================================================
    // Checks
    //==================================================

    task automatic report_failure(input string reason);
        error_count++;
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL instr_ready_o: got %h expected %h", got, exp);
            report_failure("instr_ready_o differs from the reference model");
        end
    endtask

    task automatic check_empty(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL pipeline_empty_o: got %h expected %h", got, exp);
            report_failure("pipeline_empty_o differs from the reference model");
        end
    endtask

    task automatic check_wait(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL wait cycles (%s): got %h expected %h", what, got, exp);
            report_failure("an instruction waited the wrong number of cycles");
        end
    endtask

    // Compare at every rising edge, then advance the model
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            check_ready(instr_ready_o, expected_ready());
            check_empty(pipeline_empty_o, expected_empty());
        end
        stalled = instr_valid_i && !expected_ready();
        update_model();
    end

    //==================================================
    // Stimulus helpers
    //==================================================

    // Hold one op until it issues, count the refused edges
    // Called at a falling edge and returns at a falling edge
    task automatic offer(input unit_t unit, input reg_addr_t s0, input reg_addr_t s1,
                         input reg_addr_t d, output int refused);
        refused = 0;
        instr_valid_i = 1'b1;
        instr_unit_i  = unit;
        src0_i        = s0;
        src1_i        = s1;
        dest_i        = d;
        // Mid low phase, ready has settled
        #1;
        while (!instr_ready_o) begin
            refused++;
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_empty();
        #1;
        while (!pipeline_empty_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
    endtask

    // Run limit
    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        report_failure("timeout, the run did not finish within its cycle budget");
    end

    initial begin
        void'($urandom(32'h8a8f));
        error_count   = 0;
        stalled       = 1'b0;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_unit_i  = ALU;
        src0_i        = '0;
        src1_i        = '0;
        dest_i        = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Idle scoreboard after reset
        #1;
        check_ready(instr_ready_o, 1'b1);
        check_empty(pipeline_empty_o, 1'b1);
        @(negedge clk_i);

        // RAW on x5 stalls for the whole MUL, x0 never stalls
        offer(MUL, 5'd1, 5'd2, 5'd5, waited);
        offer(ALU, 5'd5, 5'd3, 5'd6, waited);
        check_wait("raw on x5", waited, 5);
        wait_empty();
        offer(MUL, 5'd1, 5'd2, 5'd0, waited);
        offer(ALU, 5'd0, 5'd3, 5'd6, waited);
        check_wait("raw on x0", waited, 0);
        wait_empty();

        // Divider is not pipelined
        offer(DIV, 5'd1, 5'd2, 5'd3, waited);
        offer(DIV, 5'd1, 5'd2, 5'd4, waited);
        check_wait("second div", waited, 36);
        wait_empty();
        offer(DIV, 5'd1, 5'd2, 5'd3, waited);
        offer(ALU, 5'd1, 5'd2, 5'd7, waited);
        check_wait("alu beside div", waited, 0);
        wait_empty();

        // Writeback collision with the DIV result
        // A MUL right behind a MUL counts as a collision too, so offers keep one idle cycle
        offer(DIV, 5'd1, 5'd2, 5'd3, waited);
        @(negedge clk_i);
        refusals = 0;
        for (int k = 0; k < 20; k++) begin
            offer(MUL, 5'd1, 5'd2, reg_addr_t'(10 + k % 8), waited);
            refusals += waited;
            @(negedge clk_i);
        end
        check_wait("mul beside div", refusals, 1);
        wait_empty();

        // Flush with MUL and DIV results in flight
        offer(MUL, 5'd1, 5'd2, 5'd10, waited);
        offer(DIV, 5'd1, 5'd2, 5'd11, waited);
        offer(MUL, 5'd1, 5'd2, 5'd12, waited);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        #1;
        check_empty(pipeline_empty_o, 1'b1);
        check_ready(instr_ready_o, 1'b1);
        @(negedge clk_i);

        // Random stream, small register range for frequent hazards
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if (!stalled) begin
                instr_valid_i = 1'($urandom % 2);
                instr_unit_i  = unit_t'(2'($urandom % 3));
                src0_i        = reg_addr_t'($urandom % 8);
                src1_i        = reg_addr_t'($urandom % 8);
                dest_i        = reg_addr_t'($urandom % 8);
            end
            flush_i = ($urandom % 64 == 0);
            @(negedge clk_i);
        end
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        @(negedge clk_i);

        if (error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure("checks failed during the run");
        end
    end

endmodule : tb_scoreboard
